//--- hdl/trdb_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width and capacity macros of the
// trace encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TRDB_CFG_SVH
`define TRDB_CFG_SVH

// address and instruction word width
`define TRDB_XLEN 32

// trap cause width as delivered by the core
`define TRDB_CAUSE_W 5

// number of branch outcomes one packet can carry
`define TRDB_BMAP_LEN 31

// wide enough to count up to TRDB_BMAP_LEN
`define TRDB_BCNT_W 5

`endif

//--- hdl/trdb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace encoder types: instruction record,
// phase view, packet format and packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

package trdb_pkg;

    // one retired instruction as reported by the core
    typedef struct packed {
        logic [`TRDB_XLEN-1:0]    addr;
        logic [`TRDB_XLEN-1:0]    instr;
        logic                     compressed;
        logic                     exception;
        logic                     interrupt;
        logic [`TRDB_CAUSE_W-1:0] cause;
    } instr_rec_t;

    typedef enum logic [1:0] {
        FMT_BRANCH_FULL = 2'b00,
        FMT_ADDR        = 2'b01,
        FMT_SYNC_START  = 2'b10,
        FMT_SYNC_TRAP   = 2'b11
    } trdb_format_e;

    // history view around the tc instruction
    typedef struct packed {
        logic [`TRDB_XLEN-1:0]    tc_addr;
        logic                     tc_branch;
        logic                     tc_taken;
        logic                     tc_qualified;
        logic                     tc_first_qualified;
        logic                     lc_exception;
        logic [`TRDB_CAUSE_W-1:0] lc_cause;
        logic                     lc_interrupt;
        logic                     lc_discont;
        logic                     nc_exception;
        logic                     nc_unqualified;
    } phase_t;

    typedef struct packed {
        trdb_format_e              fmt;
        logic                      trace_stop;
        logic [`TRDB_BCNT_W-1:0]   count;
        logic [`TRDB_BMAP_LEN-1:0] map;
        logic [`TRDB_XLEN-1:0]     addr;
        // addr holds a difference to the last emitted address
        logic                      diff;
        logic                      interrupt;
        logic [`TRDB_CAUSE_W-1:0]  cause;
    } trdb_packet_t;

endpackage

`default_nettype wire

//--- hdl/trdb_instr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch and discontinuity classifier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

module trdb_instr_decoder (
    input  logic [`TRDB_XLEN-1:0] instr_i,
    output logic                  is_branch_o,
    output logic                  is_discont_o
);

    // conditional branches: beq, bne, blt, bge, bltu, bgeu, p.bneimm, p.beqimm
    localparam int unsigned NUM_BRANCH = 8;
    localparam logic [NUM_BRANCH-1:0][31:0] BRANCH_MASK = {
        32'h0000_707f, 32'h0000_707f, 32'h0000_707f, 32'h0000_707f,
        32'h0000_707f, 32'h0000_707f, 32'h0000_707f, 32'h0000_707f
    };
    localparam logic [NUM_BRANCH-1:0][31:0] BRANCH_MATCH = {
        32'h0000_0063, 32'h0000_1063, 32'h0000_4063, 32'h0000_5063,
        32'h0000_6063, 32'h0000_7063, 32'h0000_3063, 32'h0000_2063
    };

    // unpredictable discontinuities: jalr, mret, sret, uret
    localparam int unsigned NUM_DISCONT = 4;
    localparam logic [NUM_DISCONT-1:0][31:0] DISCONT_MASK = {
        32'h0000_707f, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff
    };
    localparam logic [NUM_DISCONT-1:0][31:0] DISCONT_MATCH = {
        32'h0000_0067, 32'h3020_0073, 32'h1020_0073, 32'h0020_0073
    };

    always_comb begin
        is_branch_o = 1'b0;
        for (int i = 0; i < NUM_BRANCH; i++) begin
            if ((instr_i & BRANCH_MASK[i]) == BRANCH_MATCH[i]) begin
                is_branch_o = 1'b1;
            end
        end
    end

    always_comb begin
        is_discont_o = 1'b0;
        for (int i = 0; i < NUM_DISCONT; i++) begin
            if ((instr_i & DISCONT_MASK[i]) == DISCONT_MATCH[i]) begin
                is_discont_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/trdb_phase_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input register and nc/tc/lc history
// with branch taken detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

module trdb_phase_pipe (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                instr_valid_i,
    input  trdb_pkg::instr_rec_t instr_i,
    input  logic                trace_enable_i,
    output logic                step_o,
    output trdb_pkg::phase_t    phase_o,
    output logic                bm_valid_o,
    output logic                bm_taken_o
);

    import trdb_pkg::*;

    // one history slot
    typedef struct packed {
        logic [`TRDB_XLEN-1:0]    addr;
        logic                     compressed;
        logic                     branch;
        logic                     discont;
        logic                     qualified;
        logic                     exception;
        logic                     interrupt;
        logic [`TRDB_CAUSE_W-1:0] cause;
    } slot_t;

    logic       valid_q;
    logic       enable_q;
    instr_rec_t rec_q;

    logic  dec_branch;
    logic  dec_discont;
    slot_t nc;
    slot_t tc_q;

    logic                     lc_qualified_q;
    logic                     lc_exception_q;
    logic                     lc_interrupt_q;
    logic [`TRDB_CAUSE_W-1:0] lc_cause_q;
    logic                     lc_discont_q;

    logic [`TRDB_XLEN-1:0] seq_addr;

    // registered inputs keep the core's timing paths short
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            valid_q  <= instr_valid_i;
            enable_q <= trace_enable_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rec_q <= instr_i;
    end

    trdb_instr_decoder instr_decoder_inst (
        .instr_i      (rec_q.instr),
        .is_branch_o  (dec_branch),
        .is_discont_o (dec_discont)
    );

    // nc is the freshly registered instruction
    always_comb begin
        nc.addr       = rec_q.addr;
        nc.compressed = rec_q.compressed;
        nc.branch     = dec_branch;
        nc.discont    = dec_discont;
        nc.qualified  = enable_q;
        nc.exception  = rec_q.exception;
        nc.interrupt  = rec_q.interrupt;
        nc.cause      = rec_q.cause;
    end

    // history only moves on retired instructions
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_q           <= '0;
            lc_qualified_q <= 1'b0;
            lc_exception_q <= 1'b0;
            lc_interrupt_q <= 1'b0;
            lc_cause_q     <= '0;
            lc_discont_q   <= 1'b0;
        end else if (valid_q) begin
            tc_q           <= nc;
            lc_qualified_q <= tc_q.qualified;
            lc_exception_q <= tc_q.exception;
            lc_interrupt_q <= tc_q.interrupt;
            lc_cause_q     <= tc_q.cause;
            lc_discont_q   <= tc_q.discont;
        end
    end

    // a branch falls through to tc + 2 or tc + 4
    assign seq_addr = tc_q.addr + (tc_q.compressed ? `TRDB_XLEN'(2) : `TRDB_XLEN'(4));

    assign step_o = valid_q;

    always_comb begin
        phase_o.tc_addr            = tc_q.addr;
        phase_o.tc_branch          = tc_q.branch;
        phase_o.tc_taken           = (nc.addr != seq_addr);
        phase_o.tc_qualified       = tc_q.qualified;
        phase_o.tc_first_qualified = tc_q.qualified && !lc_qualified_q;
        phase_o.lc_exception       = lc_exception_q;
        phase_o.lc_cause           = lc_cause_q;
        phase_o.lc_interrupt       = lc_interrupt_q;
        phase_o.lc_discont         = lc_discont_q;
        phase_o.nc_exception       = nc.exception;
        phase_o.nc_unqualified     = !nc.qualified;
    end

    assign bm_valid_o = step_o && phase_o.tc_qualified && phase_o.tc_branch;
    assign bm_taken_o = phase_o.tc_taken;

endmodule

`default_nettype wire

//--- hdl/trdb_branch_map.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch outcome map with count and full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

module trdb_branch_map (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      valid_i,
    input  logic                      taken_i,
    input  logic                      flush_i,
    output logic [`TRDB_BMAP_LEN-1:0] map_o,
    output logic [`TRDB_BCNT_W-1:0]   count_o,
    output logic                      full_o
);

    localparam logic [`TRDB_BCNT_W-1:0] FULL_CNT = `TRDB_BMAP_LEN;

    logic [`TRDB_BMAP_LEN-1:0] map_q;
    logic [`TRDB_BCNT_W-1:0]   count_q;
    logic [`TRDB_BMAP_LEN-1:0] new_bit;

    // next free slot gets the outcome, 1 means not taken
    always_comb begin
        new_bit = '0;
        if (valid_i) begin
            new_bit[count_q] = !taken_i;
        end
    end

    // outputs already contain the branch of this step
    assign map_o   = map_q | new_bit;
    assign count_o = count_q + `TRDB_BCNT_W'(valid_i);
    assign full_o  = (count_o == FULL_CNT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // current bit left with the packet
            map_q   <= '0;
            count_q <= '0;
        end else if (valid_i) begin
            map_q   <= map_o;
            count_q <= count_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/trdb_packet_decider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet priority, address compression
// and packet register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

module trdb_packet_decider (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      step_i,
    input  trdb_pkg::phase_t          phase_i,
    input  logic                      full_addr_i,
    input  logic [`TRDB_BMAP_LEN-1:0] map_i,
    input  logic [`TRDB_BCNT_W-1:0]   count_i,
    input  logic                      full_i,
    output logic                      bm_flush_o,
    output logic                      packet_valid_o,
    output trdb_pkg::trdb_packet_t    packet_o
);

    import trdb_pkg::*;

    logic                  emit;
    trdb_packet_t          pkt_d;
    logic [`TRDB_XLEN-1:0] last_addr_q;

    // first matching rule wins
    always_comb begin
        emit      = 1'b0;
        pkt_d     = '0;
        pkt_d.map   = map_i;
        pkt_d.count = count_i;
        if (step_i && phase_i.tc_qualified) begin
            if (phase_i.tc_first_qualified) begin
                emit       = 1'b1;
                pkt_d.fmt  = FMT_SYNC_START;
                pkt_d.addr = phase_i.tc_addr;
            end else if (phase_i.lc_exception) begin
                // tc is the first instruction of the trap handler
                emit            = 1'b1;
                pkt_d.fmt       = FMT_SYNC_TRAP;
                pkt_d.addr      = phase_i.tc_addr;
                pkt_d.interrupt = phase_i.lc_interrupt;
                pkt_d.cause     = phase_i.lc_cause;
            end else if (phase_i.lc_discont || phase_i.nc_exception ||
                         phase_i.nc_unqualified) begin
                emit             = 1'b1;
                pkt_d.fmt        = FMT_ADDR;
                pkt_d.trace_stop = phase_i.nc_unqualified;
                if (full_addr_i) begin
                    pkt_d.addr = phase_i.tc_addr;
                end else begin
                    pkt_d.addr = phase_i.tc_addr - last_addr_q;
                    pkt_d.diff = 1'b1;
                end
            end else if (full_i) begin
                // map only, address stays zero
                emit      = 1'b1;
                pkt_d.fmt = FMT_BRANCH_FULL;
            end
        end
    end

    // every packet takes the whole map with it
    assign bm_flush_o = emit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
            last_addr_q    <= '0;
        end else begin
            packet_valid_o <= emit;
            if (emit && (pkt_d.fmt != FMT_BRANCH_FULL)) begin
                last_addr_q <= phase_i.tc_addr;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (emit) begin
            packet_o <= pkt_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/trace_debugger.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace encoder top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

module trace_debugger (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   instr_valid_i,
    input  trdb_pkg::instr_rec_t   instr_i,
    input  logic                   trace_enable_i,
    input  logic                   full_addr_i,
    output logic                   packet_valid_o,
    output trdb_pkg::trdb_packet_t packet_o
);

    import trdb_pkg::*;

    logic   step;
    phase_t phase;

    logic                      bm_valid;
    logic                      bm_taken;
    logic                      bm_flush;
    logic [`TRDB_BMAP_LEN-1:0] bm_map;
    logic [`TRDB_BCNT_W-1:0]   bm_count;
    logic                      bm_full;

    trdb_phase_pipe phase_pipe_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .trace_enable_i (trace_enable_i),
        .step_o         (step),
        .phase_o        (phase),
        .bm_valid_o     (bm_valid),
        .bm_taken_o     (bm_taken)
    );

    // combinational path from the history through the map into the decider
    trdb_branch_map branch_map_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (bm_valid),
        .taken_i (bm_taken),
        .flush_i (bm_flush),
        .map_o   (bm_map),
        .count_o (bm_count),
        .full_o  (bm_full)
    );

    trdb_packet_decider packet_decider_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .step_i         (step),
        .phase_i        (phase),
        .full_addr_i    (full_addr_i),
        .map_i          (bm_map),
        .count_i        (bm_count),
        .full_i         (bm_full),
        .bm_flush_o     (bm_flush),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_trace_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet model, lfsr source and value
// compare for the trace encoder bench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// one instruction as the model keeps it in its history
typedef struct packed {
    logic [`TRDB_XLEN-1:0]    addr;
    logic                     compressed;
    logic                     branch;
    logic                     discont;
    logic                     qualified;
    logic                     exception;
    logic                     interrupt;
    logic [`TRDB_CAUSE_W-1:0] cause;
} model_slot_t;

logic [31:0] lfsr_state = 32'hc8c9;

model_slot_t               m_tc = '0;
model_slot_t               m_lc = '0;
logic [`TRDB_BMAP_LEN-1:0] m_map = '0;
int                        m_count = 0;
logic [`TRDB_XLEN-1:0]     m_last = '0;

// expected packets and the index of the instruction whose strobe releases them
trdb_packet_t exp_pkts [$];
int           exp_idx [$];

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
endfunction

// shifts in one lfsr output bit per step
function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
endfunction

task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("ERR %0d ns: %s got %0h expected %0h", $time, what, actual, expected);
        stop_on_failure();
    end
endtask

// history step with nc as the newest instruction and fa as its address mode
task automatic model_step(input model_slot_t nc, input logic fa, input int idx);
    trdb_packet_t pkt;
    logic         taken;
    logic         emit;
    pkt  = '0;
    emit = 1'b0;
    if (m_tc.qualified) begin
        // anything but the fall through address counts as taken
        taken = nc.addr != m_tc.addr + (m_tc.compressed ? 32'd2 : 32'd4);
        if (m_tc.branch) begin
            m_map[m_count] = !taken;
            m_count++;
        end
        pkt.map   = m_map;
        pkt.count = `TRDB_BCNT_W'(m_count);
        emit      = 1'b1;
        if (!m_lc.qualified) begin
            pkt.fmt  = FMT_SYNC_START;
            pkt.addr = m_tc.addr;
        end else if (m_lc.exception) begin
            pkt.fmt       = FMT_SYNC_TRAP;
            pkt.addr      = m_tc.addr;
            pkt.interrupt = m_lc.interrupt;
            pkt.cause     = m_lc.cause;
        end else if (m_lc.discont || nc.exception || !nc.qualified) begin
            pkt.fmt        = FMT_ADDR;
            pkt.trace_stop = !nc.qualified;
            pkt.diff       = !fa;
            pkt.addr       = fa ? m_tc.addr : m_tc.addr - m_last;
        end else if (m_count == `TRDB_BMAP_LEN) begin
            pkt.fmt = FMT_BRANCH_FULL;
        end else begin
            emit = 1'b0;
        end
        if (emit) begin
            exp_pkts.push_back(pkt);
            exp_idx.push_back(idx);
            m_map   = '0;
            m_count = 0;
            if (pkt.fmt != FMT_BRANCH_FULL) begin
                m_last = m_tc.addr;
            end
        end
    end
    m_lc = m_tc;
    m_tc = nc;
endtask

`endif

//--- tests/tb_trace_debugger.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the trace encoder with
// random instruction streams
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "trdb_cfg.svh"

`default_nettype none

module tb_trace_debugger;
    timeunit 1ns;
    timeprecision 100ps;

    import trdb_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 600;
    localparam int MAX_GAP      = 3;
    localparam int WATCHDOG_NS  =
        CLK_PERIOD * (RESET_CYCLES + NUM_INSTR * (MAX_GAP + 1) + 64);

    localparam int KIND_BRANCH = 1;
    localparam int KIND_JALR   = 2;
    localparam int KIND_MRET   = 3;

    logic         clk;
    logic         rst_n;
    logic         instr_valid;
    instr_rec_t   instr;
    logic         trace_enable;
    logic         full_addr;
    logic         packet_valid;
    trdb_packet_t packet;

    instr_rec_t recs [NUM_INSTR];
    int         kinds [NUM_INSTR];
    int         gaps [NUM_INSTR];
    logic       enables [NUM_INSTR];
    logic       full_modes [NUM_INSTR];
    int         strobe_cycle [NUM_INSTR];
    int         fmt_seen [4];
    int         cycle = 0;

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "trace encoder check failed");
    endtask

    `include "tb_trace_model.svh"

    trace_debugger trace_debugger_inst (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .trace_enable_i (trace_enable),
        .full_addr_i    (full_addr),
        .packet_valid_o (packet_valid),
        .packet_o       (packet)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // random program with long branch runs so the map can fill up
    task automatic generate_stimulus();
        logic [31:0] addr;
        logic [31:0] target;
        logic        en;
        logic        fa;
        logic        jump;
        logic        burst;
        addr = 32'h0000_1000;
        en   = 1'b1;
        fa   = 1'b0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            burst = (i % 128) >= 64 && (i % 128) < 104;
            if (burst) begin
                en = 1'b1;
            end else begin
                en = en ^ (draw_bits(5) == 0);
                fa = fa ^ (draw_bits(4) == 0);
            end
            kinds[i] = burst ? KIND_BRANCH : int'(draw_bits(2));
            gaps[i]  = draw_bits(1) ? 0 : int'(draw_bits(2));
            recs[i]  = '0;
            recs[i].addr       = addr;
            recs[i].compressed = draw_bits(1);
            recs[i].exception  = !burst && (draw_bits(5) == 0);
            if (recs[i].exception) begin
                recs[i].interrupt = draw_bits(1);
                recs[i].cause     = `TRDB_CAUSE_W'(draw_bits(`TRDB_CAUSE_W));
            end
            case (kinds[i])
                KIND_BRANCH: recs[i].instr = {25'(draw_bits(25)), 7'h63};
                KIND_JALR:   recs[i].instr = {17'(draw_bits(17)), 3'b000,
                                              5'(draw_bits(5)), 7'h67};
                KIND_MRET:   recs[i].instr = 32'h3020_0073;
                default:     recs[i].instr = {25'(draw_bits(25)), 7'h13};
            endcase
            jump = recs[i].exception || kinds[i] == KIND_JALR || kinds[i] == KIND_MRET;
            if (kinds[i] == KIND_BRANCH && !jump) begin
                jump = draw_bits(1);
            end
            target        = draw_bits(30) << 1;
            addr          = jump ? target : addr + (recs[i].compressed ? 32'd2 : 32'd4);
            enables[i]    = en;
            full_modes[i] = fa;
        end
    endtask

    task automatic run_model();
        model_slot_t nc;
        logic        fa;
        for (int j = 0; j < NUM_INSTR; j++) begin
            nc.addr       = recs[j].addr;
            nc.compressed = recs[j].compressed;
            nc.branch     = kinds[j] == KIND_BRANCH;
            nc.discont    = kinds[j] == KIND_JALR || kinds[j] == KIND_MRET;
            nc.qualified  = enables[j];
            nc.exception  = recs[j].exception;
            nc.interrupt  = recs[j].interrupt;
            nc.cause      = recs[j].cause;
            // address mode is read in the cycle after the strobe
            fa = (j + 1 < NUM_INSTR && gaps[j + 1] == 0) ? full_modes[j + 1] : full_modes[j];
            model_step(nc, fa, j);
        end
    endtask

    task automatic drive_instr(input int j);
        repeat (gaps[j]) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        instr_valid     = 1'b1;
        instr           = recs[j];
        trace_enable    = enables[j];
        full_addr       = full_modes[j];
        strobe_cycle[j] = cycle;
    endtask

    task automatic check_packet();
        trdb_packet_t exp;
        int           idx;
        if (exp_pkts.size() == 0) begin
            $display("packet at %0d ns but the model expects no more packets", $time);
            stop_on_failure();
        end else begin
            exp = exp_pkts.pop_front();
            idx = exp_idx.pop_front();
            check_value(cycle, strobe_cycle[idx] + 2, $sformatf("cycle after instr %0d", idx));
            check_value(packet.fmt, exp.fmt, $sformatf("format after instr %0d", idx));
            check_value(packet, exp, $sformatf("packet after instr %0d", idx));
            fmt_seen[exp.fmt]++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (packet_valid) begin
            check_packet();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        stop_on_failure();
    end

    initial begin
        int missing_fmt;
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        trace_enable = 1'b0;
        full_addr    = 1'b0;
        missing_fmt  = 0;
        generate_stimulus();
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int j = 0; j < NUM_INSTR; j++) begin
            drive_instr(j);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        // the last packet is due 2 cycles after the final strobe
        repeat (4) @(posedge clk);
        for (int f = 0; f < 4; f++) begin
            if (fmt_seen[f] == 0) begin
                missing_fmt++;
            end
        end
        if (exp_pkts.size() != 0 || missing_fmt != 0) begin
            $display("run ended with %0d packets not seen and %0d formats never produced",
                     exp_pkts.size(), missing_fmt);
            stop_on_failure();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
+incdir+tests
hdl/trdb_pkg.sv
hdl/trdb_instr_decoder.sv
hdl/trdb_phase_pipe.sv
hdl/trdb_branch_map.sv
hdl/trdb_packet_decider.sv
hdl/trace_debugger.sv
tests/tb_trace_debugger.sv

//--- Bender.yml
package:
  name: trace_debugger

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/trdb_pkg.sv
      - hdl/trdb_instr_decoder.sv
      - hdl/trdb_phase_pipe.sv
      - hdl/trdb_branch_map.sv
      - hdl/trdb_packet_decider.sv
      - hdl/trace_debugger.sv
  - target: test
    include_dirs:
      - hdl
      - tests
    files:
      - tests/tb_trace_debugger.sv
